// ==== envelope_gen.sv ====
module envelope_gen
	import synth_pkg::*;
(
	input logic clk37,
	input logic rst,
	voice_slot_if.env slot,
	op_result_if.env res
);

	env_state_e env_st [NUM_OPS];
	logic [31:0] env_cnt [NUM_OPS]; // Frames spent in the current state
	env_amp_t env_amp [NUM_OPS];

	env_state_e cur_st;
	env_state_e nxt_st;
	logic [31:0] cur_cnt;
	logic [31:0] nxt_cnt;
	logic [31:0] cnt_inc;
	env_amp_t cur_amp;
	env_amp_t nxt_amp;
	env_amp_t rel_amp;
	env_amp_t amp_q;

	assign cur_st = env_st[slot.slot];
	assign cur_cnt = env_cnt[slot.slot];
	assign cur_amp = env_amp[slot.slot];
	assign cnt_inc = cur_cnt + 32'd1;
	assign rel_amp = cur_amp + slot.env_params.re_inc;

	always_comb begin
		nxt_st = cur_st;
		nxt_cnt = cur_cnt;
		nxt_amp = cur_amp;
		case (cur_st)
			ENV_IDLE: begin
				if (slot.gate) nxt_st = ENV_ATTACK;
			end
			ENV_ATTACK: begin
				nxt_cnt = cnt_inc;
				nxt_amp = cur_amp + slot.env_params.at_inc;
				if (!slot.gate) begin
					nxt_st = ENV_RELEASE;
					nxt_cnt = '0;
				end else if (cur_cnt == slot.env_params.at_time) begin
					nxt_st = ENV_DECAY;
					nxt_cnt = '0;
				end
			end
			ENV_DECAY: begin
				nxt_cnt = cnt_inc;
				nxt_amp = cur_amp + slot.env_params.de_inc;
				if (!slot.gate) begin
					nxt_st = ENV_RELEASE;
					nxt_cnt = '0;
				end else if (cur_cnt == slot.env_params.de_time) begin
					nxt_st = ENV_SUSTAIN;
					nxt_cnt = '0;
				end
			end
			ENV_SUSTAIN: begin
				nxt_cnt = cnt_inc;
				nxt_amp = slot.env_params.su_lvl; // Level held, not stepped
				if (!slot.gate || cur_cnt == slot.env_params.su_time) begin
					nxt_st = ENV_RELEASE;
					nxt_cnt = '0;
				end
			end
			ENV_RELEASE: begin
				nxt_cnt = cnt_inc;
				nxt_amp = rel_amp;
				// Early exit keeps the level from going below zero
				if (cur_cnt == slot.env_params.re_time || rel_amp < 0) begin
					nxt_st = ENV_IDLE;
					nxt_cnt = '0;
					nxt_amp = '0;
				end
			end
			default: nxt_st = ENV_IDLE;
		endcase
	end

	always_ff @(posedge clk37) begin
		if (rst) begin
			for (int k = 0; k < NUM_OPS; k++) begin
				env_st[k] <= ENV_IDLE;
				env_cnt[k] <= '0;
				env_amp[k] <= '0;
			end
			amp_q <= '0;
			res.level <= '0;
		end else begin
			if (slot.slot_valid) begin
				env_st[slot.slot] <= nxt_st;
				env_cnt[slot.slot] <= nxt_cnt;
				env_amp[slot.slot] <= nxt_amp;
			end
			amp_q <= nxt_amp;
			res.level <= env_level(amp_q); // Lines up with the wave
		end
	end

endmodule

// ==== fm_voice.sv ====
module fm_voice (
	input logic clk37,
	input logic rst,
	input logic cmd_valid,
	input logic [31:0] cmd_data,
	output synth_pkg::sample_t sample,
	output logic sample_valid,
	output logic cmd_busy
);

	voice_slot_if slot_bus ();
	op_result_if res_bus ();

	voice_control voice_control_inst (
		.clk37(clk37),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_data(cmd_data),
		.cmd_busy(cmd_busy),
		.slot(slot_bus.ctrl)
	);

	phase_oscillator phase_oscillator_inst (
		.clk37(clk37),
		.rst(rst),
		.slot(slot_bus.osc),
		.res(res_bus.osc)
	);

	envelope_gen envelope_gen_inst (
		.clk37(clk37),
		.rst(rst),
		.slot(slot_bus.env),
		.res(res_bus.env)
	);

	voice_mixer voice_mixer_inst (
		.clk37(clk37),
		.rst(rst),
		.slot(slot_bus.mix),
		.res(res_bus.mix),
		.sample(sample),
		.sample_valid(sample_valid)
	);

endmodule

// ==== list.f ====
+incdir+.
synth_pkg.sv
voice_slot_if.sv
op_result_if.sv
param_bank.sv
voice_control.sv
phase_oscillator.sv
envelope_gen.sv
voice_mixer.sv
fm_voice.sv
tb_fm_voice.sv

// ==== op_result_if.sv ====
interface op_result_if
	import synth_pkg::*;
();

	// All valid two cycles after the slot was issued
	logic res_valid;
	op_idx_t res_slot;
	wave_t wave;
	level_t level;

	modport osc (output res_valid, res_slot, wave);

	modport env (output level);

	modport mix (input res_valid, res_slot, wave, level);

endinterface

// ==== param_bank.sv ====
module param_bank
	import synth_pkg::*;
#(
	parameter type payload_t = phase_t
) (
	input logic clk37,
	input logic rst,
	input logic wr_en,
	input op_idx_t wr_idx,
	input payload_t wr_data,
	input op_idx_t rd_idx,
	output payload_t rd_data
);

	payload_t entry [NUM_OPS];

	always_ff @(posedge clk37) begin
		if (rst) begin
			for (int k = 0; k < NUM_OPS; k++) begin
				entry[k] <= '0;
			end
		end else if (wr_en) begin
			entry[wr_idx] <= wr_data; // Index checked by the caller
		end
	end

	assign rd_data = entry[rd_idx];

endmodule

// ==== phase_oscillator.sv ====
module phase_oscillator
	import synth_pkg::*;
(
	input logic clk37,
	input logic rst,
	voice_slot_if.osc slot,
	op_result_if.osc res
);

	wave_t wave_rom [WAVE_DEPTH];
	phase_t phase_acc [NUM_OPS];
	phase_t phase_new;
	logic s1_valid;
	op_idx_t s1_slot;
	logic [WAVE_ADDR_W-1:0] s1_addr;

	// One full sine period, peak 127
	initial begin
		for (int i = 0; i < WAVE_DEPTH; i++) begin
			wave_rom[i] = wave_t'(int'(WAVE_PEAK * $sin(TWO_PI * real'(i) / real'(WAVE_DEPTH))));
		end
	end

	assign phase_new = phase_acc[slot.slot] + slot.phase_inc;

	always_ff @(posedge clk37) begin
		if (rst) begin
			for (int k = 0; k < NUM_OPS; k++) begin
				phase_acc[k] <= '0;
			end
			s1_valid <= 1'b0;
			res.res_valid <= 1'b0;
		end else begin
			if (slot.slot_valid) begin
				phase_acc[slot.slot] <= phase_new; // Once per frame for each operator
			end
			s1_valid <= slot.slot_valid;
			res.res_valid <= s1_valid;
		end
	end

	// Table read uses the updated phase
	always_ff @(posedge clk37) begin
		s1_slot <= slot.slot;
		s1_addr <= phase_new[PHASE_W-1 -: WAVE_ADDR_W];
		res.res_slot <= s1_slot;
		res.wave <= wave_rom[s1_addr];
	end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fm_voice -f list.f &&
./obj_dir/Vtb_fm_voice > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Everything OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== synth_pkg.sv ====
package synth_pkg;

	localparam int NUM_OPS = 6;
	typedef logic [2:0] op_idx_t;

	// Oscillator
	localparam int PHASE_W = 32;
	typedef logic [PHASE_W-1:0] phase_t;
	localparam int WAVE_ADDR_W = 8; // Top phase bits used as table address
	localparam int WAVE_DEPTH = 1 << WAVE_ADDR_W;
	localparam int WAVE_PEAK = 127;
	localparam real TWO_PI = 6.283185307179586;
	typedef logic signed [7:0] wave_t;

	// Envelope and mixing
	typedef logic signed [31:0] env_amp_t;
	typedef logic signed [15:0] level_t; // Upper half of env_amp_t
	typedef logic signed [15:0] contrib_t;
	localparam int CONTRIB_SHIFT = 8;
	localparam int MIX_W = 19; // Six full-scale contributions fit
	typedef logic signed [MIX_W-1:0] mix_acc_t;
	localparam int SAMPLE_SHIFT = 3;
	typedef logic signed [15:0] sample_t;

	typedef enum logic [2:0] {
		ENV_IDLE,
		ENV_ATTACK,
		ENV_DECAY,
		ENV_SUSTAIN,
		ENV_RELEASE
	} env_state_e;

	// Field order is the order of the set_env data words
	typedef struct packed {
		logic [31:0] at_time;
		logic signed [31:0] at_inc;
		logic [31:0] de_time;
		logic signed [31:0] de_inc;
		logic [31:0] su_time;
		logic signed [31:0] su_lvl;
		logic [31:0] re_time;
		logic signed [31:0] re_inc;
	} env_params_t;

	// Command stream
	typedef enum logic [7:0] {
		CMD_NOP = 8'd0,
		CMD_SET_ENV = 8'd1,
		CMD_KEY = 8'd2,
		CMD_SET_FREQ = 8'd3
	} cmd_code_e;

	localparam int ENV_WORDS = 8;
	localparam int FREQ_WORDS = 1;
	typedef logic [NUM_OPS-1:0] mix_mask_t;

	function automatic level_t env_level(env_amp_t amp);
		return amp[31:16];
	endfunction

	// 24-bit product of wave and level, scaled back to 16 bits
	function automatic contrib_t op_contrib(wave_t wave, level_t level);
		logic signed [23:0] prod;
		prod = wave * level;
		return contrib_t'(prod >>> CONTRIB_SHIFT);
	endfunction

	function automatic sample_t mix_scale(mix_acc_t acc);
		return sample_t'(acc >>> SAMPLE_SHIFT);
	endfunction

endpackage

// ==== tb_voice_model.svh ====
`ifndef TB_VOICE_MODEL_SVH
`define TB_VOICE_MODEL_SVH

// Number of data words announced by a header code
function automatic int words_after(input logic [7:0] code);
	case (code)
		CMD_SET_ENV: return ENV_WORDS;
		CMD_SET_FREQ: return FREQ_WORDS;
		default: return 0;
	endcase
endfunction

// Table entry as 127 sin(2 pi i / 256), rounded to nearest
function automatic int sine_entry(input int addr);
	real w;
	w = 127.0 * $sin(6.283185307179586 * real'(addr) / 256.0);
	return (w < 0.0) ? -$rtoi(0.5 - w) : $rtoi(w + 0.5);
endfunction

// Sample of ops equal operators at one table address and one sustain level
function automatic int expected_sample(input int ops, input int addr, input logic [31:0] amp);
	int level;
	int contrib;
	level = $signed(amp[31:16]); // Upper half of the amplitude
	contrib = (sine_entry(addr) * level) >>> 8;
	return (ops * contrib) >>> 3;
endfunction

task automatic send_word(input logic [31:0] word, input bit gaps);
	int idle;
	idle = gaps ? int'($urandom % 4) : 0;
	repeat (idle) begin
		@(posedge clk37);
		cmd_valid <= 1'b0;
	end
	@(posedge clk37);
	cmd_valid <= 1'b1;
	cmd_data <= word;
endtask

task automatic end_command();
	@(posedge clk37);
	cmd_valid <= 1'b0;
endtask

task automatic send_env(input logic [2:0] idx, input env_params_t env, input bit gaps);
	send_word({CMD_SET_ENV, 5'd0, idx, 16'd0}, gaps);
	for (int k = 0; k < ENV_WORDS; k++) begin
		send_word(env[32 * (ENV_WORDS - 1 - k) +: 32], gaps); // at_time goes first
	end
	end_command();
endtask

task automatic send_freq(input logic [2:0] idx, input logic [31:0] inc, input bit gaps);
	send_word({CMD_SET_FREQ, 5'd0, idx, 16'd0}, gaps);
	send_word(inc, gaps);
	end_command();
endtask

task automatic send_key(input logic gate, input logic [5:0] mask);
	send_word({CMD_KEY, 10'd0, mask, 7'd0, gate}, 1'b0);
	end_command();
endtask

`endif

// ==== tb_fm_voice.sv ====
module tb_fm_voice
	import synth_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'h37a2_04dc;
	localparam logic [31:0] QUARTER_TURN = 32'h4000_0000;

	logic clk37 = 1'b0;
	logic rst;
	logic cmd_valid;
	logic [31:0] cmd_data;
	sample_t sample;
	logic sample_valid;
	logic cmd_busy;

	int check_errors = 0;
	int timeout_errors = 0;
	bit chk_zero = 1'b1; // All samples must be silent
	int chk_ops = 0; // Operators in sustain or 0 for no level check
	int exp_pos = 0;
	int exp_neg = 0;
	int last_nz = 0;
	bit last_zero = 1'b0;
	int since_sv = 0;
	bit seen_sv = 1'b0;
	int busy_words = 0;

	`include "tb_voice_model.svh"

	fm_voice fm_voice_inst (
		.clk37(clk37),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_data(cmd_data),
		.sample(sample),
		.sample_valid(sample_valid),
		.cmd_busy(cmd_busy)
	);

	always #20 clk37 = ~clk37;

	// Reference for the strobe spacing and the command framing
	always @(posedge clk37) begin
		if (rst) begin
			since_sv <= 0;
			seen_sv <= 1'b0;
			busy_words <= 0;
		end else begin
			since_sv <= sample_valid ? 1 : since_sv + 1;
			if (sample_valid) seen_sv <= 1'b1;
			if (cmd_valid) begin
				busy_words <= (busy_words != 0) ? busy_words - 1 : words_after(cmd_data[31:24]);
			end
		end
	end

	always @(posedge clk37) begin
		if (chk_ops == 0) begin
			last_nz <= 0;
			last_zero <= 1'b0;
		end else if (sample_valid) begin
			last_zero <= (sample == 0);
			if (sample != 0) last_nz <= sample;
		end
	end

	a_spacing: assert property (@(posedge clk37) disable iff (rst)
		sample_valid && seen_sv |-> since_sv == 6)
	else begin
		check_errors = check_errors + 1;
		$display("Mismatch at %0t: sample_valid spacing = %0d, expected 6", $time,
			$sampled(since_sv));
	end

	a_strobe_missing: assert property (@(posedge clk37) disable iff (rst)
		seen_sv |-> since_sv <= 6)
	else begin
		check_errors = check_errors + 1;
		$display("At %0t the sample strobe did not come within 6 cycles", $time);
	end

	a_busy: assert property (@(posedge clk37) disable iff (rst) cmd_busy == (busy_words != 0))
	else begin
		check_errors = check_errors + 1;
		$display("Mismatch at %0t: cmd_busy = %0b, expected %0b", $time, $sampled(cmd_busy),
			$sampled(busy_words) != 0);
	end

	a_silent: assert property (@(posedge clk37) disable iff (rst)
		sample_valid && chk_zero |-> sample == 0)
	else begin
		check_errors = check_errors + 1;
		$display("Mismatch at %0t: sample = %0d, expected 0", $time, $sampled(sample));
	end

	a_level: assert property (@(posedge clk37) disable iff (rst)
		sample_valid && chk_ops != 0 |-> sample == 0 || sample == exp_pos || sample == exp_neg)
	else begin
		check_errors = check_errors + 1;
		$display("Mismatch at %0t: sample = %0d, expected one of 0, %0d, %0d", $time,
			$sampled(sample), exp_pos, exp_neg);
	end

	// Quarter-turn steps put one zero sample between two peaks
	a_peak: assert property (@(posedge clk37) disable iff (rst)
		sample_valid && chk_ops != 0 && last_zero |-> sample != 0)
	else begin
		check_errors = check_errors + 1;
		$display("Mismatch at %0t: sample = %0d after a zero sample, expected %0d or %0d",
			$time, $sampled(sample), exp_pos, exp_neg);
	end

	a_sign: assert property (@(posedge clk37) disable iff (rst)
		sample_valid && chk_ops != 0 && sample != 0 && last_nz != 0
		|-> (sample < 0) != (last_nz < 0))
	else begin
		check_errors = check_errors + 1;
		$display("Mismatch at %0t: sample = %0d, expected sign opposite to %0d", $time,
			$sampled(sample), $sampled(last_nz));
	end

	task automatic wait_samples(input int count);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count && cycles < count * NUM_OPS + 24) begin
			@(negedge clk37);
			cycles++;
			if (sample_valid) seen++;
		end
		if (seen < count) begin
			timeout_errors++;
			$display("Timeout at %0t: %0d of %0d sample strobes arrived", $time, seen, count);
		end
	endtask

	// Four zero frames in a row cover a negative half wave too
	task automatic wait_silence(input int frames);
		int zeros;
		int cycles;
		zeros = 0;
		cycles = 0;
		while (zeros < 4 && cycles < frames * NUM_OPS) begin
			@(negedge clk37);
			cycles++;
			if (sample_valid) zeros = (sample == 0) ? zeros + 1 : 0;
		end
		if (zeros < 4) begin
			timeout_errors++;
			$display("Timeout at %0t: samples did not fall to zero after gate off", $time);
		end
	endtask

	initial begin
		env_params_t env;
		env_params_t junk;
		void'($urandom(SEED));
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_data = '0;
		env.at_time = 32'd3;
		env.at_inc = 32'h1000_0000; // Four steps up to the sustain level
		env.de_time = 32'd1;
		env.de_inc = 32'd0;
		env.su_time = 32'hffff_ffff;
		env.su_lvl = 32'h4000_0000;
		env.re_time = 32'd40;
		env.re_inc = 32'hfc00_0000;
		repeat (3) @(posedge clk37);
		rst <= 1'b0;
		wait_samples(4);

		send_env(3'd0, env, 1'b1);
		send_env(3'd1, env, 1'b1);
		send_freq(3'd2, 32'h0123_4567, 1'b1);
		// Land both increments in one frame so operators 0 and 1 share a phase
		wait_samples(1);
		@(posedge clk37);
		send_freq(3'd0, QUARTER_TURN, 1'b0);
		send_freq(3'd1, QUARTER_TURN, 1'b0);
		wait_samples(2);

		chk_zero = 1'b0;
		send_key(1'b1, 6'b000001);
		wait_samples(10);
		exp_pos = expected_sample(1, 64, env.su_lvl); // Quarter turn lands on 64 and 192
		exp_neg = expected_sample(1, 192, env.su_lvl);
		chk_ops = 1;
		wait_samples(12);

		for (int k = 0; k < ENV_WORDS; k++) begin
			junk[32 * k +: 32] = $urandom;
		end
		send_env(3'd7, junk, 1'b1);
		wait_samples(12);

		chk_ops = 0;
		send_key(1'b1, 6'b000011);
		wait_samples(3);
		exp_pos = expected_sample(2, 64, env.su_lvl);
		exp_neg = expected_sample(2, 192, env.su_lvl);
		chk_ops = 2;
		wait_samples(12);
		chk_ops = 0;
		send_key(1'b1, 6'b000000);
		wait_samples(2);
		chk_zero = 1'b1;
		wait_samples(8);

		chk_zero = 1'b0;
		send_key(1'b0, 6'b000011);
		wait_silence(env.re_time + 8);
		chk_zero = 1'b1;
		wait_samples(12);

		$display("Errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== voice_control.sv ====
module voice_control
	import synth_pkg::*;
(
	input logic clk37,
	input logic rst,
	input logic cmd_valid,
	input logic [31:0] cmd_data,
	output logic cmd_busy,
	voice_slot_if.ctrl slot
);

	cmd_code_e hdr_code;
	op_idx_t hdr_idx;
	cmd_code_e cur_code; // Command whose data words are arriving
	op_idx_t cur_idx;
	logic [3:0] words_left;
	logic last_word;
	logic idx_ok;
	env_params_t env_stage;
	env_params_t env_wr_data;
	logic env_wr_en;
	logic freq_wr_en;

	assign hdr_code = cmd_code_e'(cmd_data[31:24]);
	assign hdr_idx = cmd_data[18:16];

	assign last_word = cmd_busy && cmd_valid && (words_left == 4'd1);
	assign idx_ok = cur_idx < NUM_OPS; // Index 6 or 7 just drains the words

	assign env_wr_en = last_word && idx_ok && (cur_code == CMD_SET_ENV);
	assign freq_wr_en = last_word && idx_ok && (cur_code == CMD_SET_FREQ);

	// Last word goes straight into the bank with the staged fields
	always_comb begin
		env_wr_data = env_stage;
		env_wr_data.re_inc = cmd_data;
	end

	always_ff @(posedge clk37) begin
		if (rst) begin
			cmd_busy <= 1'b0;
			words_left <= '0;
			cur_code <= CMD_NOP;
			cur_idx <= '0;
			slot.gate <= 1'b0;
			slot.mix_mask <= '0;
		end else if (cmd_valid) begin
			if (cmd_busy) begin
				words_left <= words_left - 4'd1;
				if (words_left == 4'd1) begin
					cmd_busy <= 1'b0;
				end
			end else begin
				cur_code <= hdr_code;
				cur_idx <= hdr_idx;
				case (hdr_code)
					CMD_SET_ENV: begin
						cmd_busy <= 1'b1;
						words_left <= 4'(ENV_WORDS);
					end
					CMD_SET_FREQ: begin
						cmd_busy <= 1'b1;
						words_left <= 4'(FREQ_WORDS);
					end
					CMD_KEY: begin
						slot.gate <= cmd_data[0];
						slot.mix_mask <= cmd_data[13:8];
					end
					default: ; // NOP and unknown codes
				endcase
			end
		end
	end

	// First data word lands in the top field
	always_ff @(posedge clk37) begin
		if (cmd_valid && cmd_busy && cur_code == CMD_SET_ENV) begin
			env_stage[32 * (words_left - 4'd1) +: 32] <= cmd_data;
		end
	end

	// Slot sequencer, one operator per cycle
	always_ff @(posedge clk37) begin
		if (rst) begin
			slot.slot <= '0;
			slot.slot_valid <= 1'b0;
		end else begin
			slot.slot_valid <= 1'b1;
			if (slot.slot_valid) begin
				slot.slot <= (slot.slot == NUM_OPS - 1) ? '0 : slot.slot + 3'd1;
			end
		end
	end

	param_bank #(.payload_t(env_params_t)) env_bank (
		.clk37(clk37),
		.rst(rst),
		.wr_en(env_wr_en),
		.wr_idx(cur_idx),
		.wr_data(env_wr_data),
		.rd_idx(slot.slot),
		.rd_data(slot.env_params)
	);

	param_bank #(.payload_t(phase_t)) freq_bank (
		.clk37(clk37),
		.rst(rst),
		.wr_en(freq_wr_en),
		.wr_idx(cur_idx),
		.wr_data(cmd_data),
		.rd_idx(slot.slot),
		.rd_data(slot.phase_inc)
	);

endmodule

// ==== voice_mixer.sv ====
module voice_mixer
	import synth_pkg::*;
(
	input logic clk37,
	input logic rst,
	voice_slot_if.mix slot,
	op_result_if.mix res,
	output sample_t sample,
	output logic sample_valid
);

	logic mix_valid;
	op_idx_t mix_slot;
	contrib_t contrib_q;
	mix_acc_t acc;
	mix_acc_t mix_sum;
	logic frame_end;

	// Masked operators add nothing
	always_ff @(posedge clk37) begin
		mix_slot <= res.res_slot;
		contrib_q <= slot.mix_mask[res.res_slot] ? op_contrib(res.wave, res.level) : '0;
	end

	assign mix_sum = acc + contrib_q;
	assign frame_end = mix_valid && (mix_slot == NUM_OPS - 1);

	always_ff @(posedge clk37) begin
		if (rst) begin
			mix_valid <= 1'b0;
			acc <= '0;
			sample_valid <= 1'b0;
		end else begin
			mix_valid <= res.res_valid;
			sample_valid <= frame_end;
			if (frame_end) begin
				acc <= '0; // Next frame starts clean
			end else if (mix_valid) begin
				acc <= mix_sum;
			end
		end
	end

	always_ff @(posedge clk37) begin
		if (frame_end) sample <= mix_scale(mix_sum);
	end

endmodule

// ==== voice_slot_if.sv ====
interface voice_slot_if
	import synth_pkg::*;
();

	op_idx_t slot; // Operator served this cycle
	logic slot_valid;
	logic gate;
	phase_t phase_inc; // Settings of the current slot
	env_params_t env_params;
	mix_mask_t mix_mask;

	modport ctrl (
		output slot, slot_valid, gate, phase_inc, env_params, mix_mask
	);

	modport osc (input slot, slot_valid, phase_inc);

	modport env (input slot, slot_valid, gate, env_params);

	modport mix (input mix_mask);

endinterface
